/* credit_pkg.sv */
// shared apb types, credit register map, apb slave phase enum, queue address width helper
package credit_pkg;

  // ------------------------------------------------------------------
  // apb bus types
  // ------------------------------------------------------------------

  // byte address seen on paddr
  typedef logic [11:0] apb_addr_t;

  // data word on pwdata and prdata
  // credit counts are zero-extended into it
  typedef logic [31:0] apb_data_t;

  // apb slave state machine
  // idle covers setup and write access cycles
  // read_wait is the cycle that presents ram read data with pready
  typedef enum logic [0:0] {
    phase_idle      = 1'b0,
    phase_read_wait = 1'b1
  } apb_phase_t;

  // ------------------------------------------------------------------
  // register map
  // ------------------------------------------------------------------

  // queue 0 register, queue i lives at base + 4*i
  localparam apb_addr_t CREDIT_REG_BASE = 12'h000;

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------

  // bits needed to index count entries, never less than one
  function automatic int queue_addr_width(input int count);
    int bits;
    bits = 1;
    // grow until count-1 fits
    while (((count - 1) >> bits) > 0) begin
      bits++;
    end
    return bits;
  endfunction

endpackage

/* credit_ram.sv */
// flop-based credit ram with two write ports, one registered read port and reset load
`timescale 1ns/100ps

module credit_ram #(
  parameter int NUM_QUEUES   = 8,
  parameter int CREDIT_WIDTH = 8,
  parameter int INIT_CREDIT  = 4
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  // write port 1, apb side
  input  logic                                                we,
  input  logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] waddr,
  input  logic [CREDIT_WIDTH-1:0]                             wdata,
  // write port 2, grant writeback side
  input  logic                                                we2,
  input  logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] waddr2,
  input  logic [CREDIT_WIDTH-1:0]                             wdata2,
  // shared read port
  input  logic                                                re,
  input  logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] raddr,
  output logic [CREDIT_WIDTH-1:0]                             rdata
);

  // one credit count per queue
  logic [CREDIT_WIDTH-1:0] mem [NUM_QUEUES];

  // ------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------

  // every entry comes out of reset holding the initial credit
  // port 2 is applied last so it wins on an address collision
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_QUEUES; i++) begin
        mem[i] <= CREDIT_WIDTH'(INIT_CREDIT);
      end
    end else begin
      if (we) begin
        mem[waddr] <= wdata;
      end
      if (we2) begin
        mem[waddr2] <= wdata2;
      end
    end
  end

  // ------------------------------------------------------------------
  // read port
  // ------------------------------------------------------------------

  // data shows up one cycle after re
  // sees the array before this cycle's writes
  // zero when no read was issued
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (re) begin
      rdata <= mem[raddr];
    end else begin
      rdata <= '0;
    end
  end

  // ------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------

  // both writers decode their own addresses, so keep them inside the array
  a_waddr_range: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> (int'(waddr) < NUM_QUEUES));
  a_waddr2_range: assert property (@(posedge clk) disable iff (!rst_n)
    we2 |-> (int'(waddr2) < NUM_QUEUES));

  // the read mux in the top level must not hand over a stray index
  a_raddr_range: assert property (@(posedge clk) disable iff (!rst_n)
    re |-> (int'(raddr) < NUM_QUEUES));

endmodule

/* credit_apb_regs.sv */
// apb slave mapping one credit register per queue onto ram write port 1 and the read port
`timescale 1ns/100ps

module credit_apb_regs #(
  parameter int NUM_QUEUES   = 8,
  parameter int CREDIT_WIDTH = 8
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  // apb slave
  input  logic                                                psel,
  input  logic                                                penable,
  input  logic                                                pwrite,
  input  credit_pkg::apb_addr_t                               paddr,
  input  credit_pkg::apb_data_t                               pwdata,
  output credit_pkg::apb_data_t                               prdata,
  output logic                                                pready,
  // grant traffic owns the read port whenever a request is present
  input  logic                                                req_valid,
  // ram write port 1
  output logic                                                ram_we,
  output logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] ram_waddr,
  output logic [CREDIT_WIDTH-1:0]                             ram_wdata,
  // ram read port, low priority
  output logic                                                ram_re,
  output logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] ram_raddr,
  input  logic [CREDIT_WIDTH-1:0]                             ram_rdata
);

  import credit_pkg::*;

  localparam int QAW = queue_addr_width(NUM_QUEUES);

  apb_phase_t      state;
  apb_phase_t      state_nxt;
  apb_addr_t       offset;
  logic [QAW-1:0]  queue_idx;
  logic            access;
  logic            rd_issue;

  // ------------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------------

  // registers are word spaced from the base
  // bits above the queue index are dropped
  assign offset    = paddr - CREDIT_REG_BASE;
  assign queue_idx = offset[2 +: QAW];

  // second and later cycles of a transfer
  assign access = psel && penable;

  // ------------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------------

  // a read may only start in a cycle the grant pipeline leaves free
  assign rd_issue = (state == phase_idle) && access && !pwrite && !req_valid;

  always_comb begin
    state_nxt = state;
    case (state)
      phase_idle: begin
        if (rd_issue) begin
          state_nxt = phase_read_wait;
        end
      end
      phase_read_wait: begin
        // data is on ram_rdata now, transfer completes this cycle
        state_nxt = phase_idle;
      end
      default: begin
        state_nxt = phase_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= phase_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // ------------------------------------------------------------------
  // ram side
  // ------------------------------------------------------------------

  // writes finish in the first access cycle
  // the ram takes them on the completing edge
  assign ram_we    = (state == phase_idle) && access && pwrite;
  assign ram_waddr = queue_idx;
  assign ram_wdata = pwdata[CREDIT_WIDTH-1:0];

  // single-cycle read request
  assign ram_re    = rd_issue;
  assign ram_raddr = queue_idx;

  // ------------------------------------------------------------------
  // apb response
  // ------------------------------------------------------------------

  // write: ready at once
  // read: ready in the cycle after the ram read
  assign pready = (ram_we) || (state == phase_read_wait);

  // zero-extended count, quiet outside the read data phase
  assign prdata = (state == phase_read_wait) ? apb_data_t'(ram_rdata) : '0;

  // ------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------

  // the master keeps psel and penable up until ready, so no early ready
  a_pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(pready) |-> access);

  // the grant unit holds the read port while req_valid is high
  a_re_vs_req: assert property (@(posedge clk) disable iff (!rst_n)
    !(ram_re && req_valid));

endmodule

/* credit_grant.sv */
// grant pipeline with stage 0 read issue, stage 1 forwarding and decision, decrement writeback and response
`timescale 1ns/100ps

module credit_grant #(
  parameter int NUM_QUEUES   = 8,
  parameter int CREDIT_WIDTH = 8
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  // request stream accepted every cycle
  input  logic                                                req_valid,
  input  logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] req_queue,
  // ram read port with priority over apb reads
  output logic                                                ram_re,
  output logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] ram_raddr,
  input  logic [CREDIT_WIDTH-1:0]                             ram_rdata,
  // copy of ram write port 1
  input  logic                                                snoop_we,
  input  logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] snoop_waddr,
  input  logic [CREDIT_WIDTH-1:0]                             snoop_wdata,
  // ram write port 2
  output logic                                                ram_we2,
  output logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] ram_waddr2,
  output logic [CREDIT_WIDTH-1:0]                             ram_wdata2,
  // response two edges after the request is sampled
  output logic                                                resp_valid,
  output logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] resp_queue,
  output logic                                                resp_grant
);

  import credit_pkg::*;

  localparam int QAW = queue_addr_width(NUM_QUEUES);

  // stage 1 request
  logic                    s1_valid;
  logic [QAW-1:0]          s1_queue;
  logic [CREDIT_WIDTH-1:0] s1_count;
  logic                    s1_grant;

  // decision on its way to the response register
  logic                    s2_valid;
  logic [QAW-1:0]          s2_queue;
  logic                    s2_grant;

  // writes made during the stage 0 cycle, which the ram read missed
  logic                    wb_valid_q;
  logic [QAW-1:0]          wb_queue_q;
  logic [CREDIT_WIDTH-1:0] wb_data_q;
  logic                    snoop_valid_q;
  logic [QAW-1:0]          snoop_queue_q;
  logic [CREDIT_WIDTH-1:0] snoop_data_q;

  // ------------------------------------------------------------------
  // stage 0 read issue
  // ------------------------------------------------------------------

  assign ram_re    = req_valid;
  assign ram_raddr = req_queue;

  // valid bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid      <= 1'b0;
      s2_valid      <= 1'b0;
      wb_valid_q    <= 1'b0;
      snoop_valid_q <= 1'b0;
      resp_valid    <= 1'b0;
    end else begin
      s1_valid      <= req_valid;
      s2_valid      <= s1_valid;
      wb_valid_q    <= ram_we2;
      snoop_valid_q <= snoop_we;
      resp_valid    <= s2_valid;
    end
  end

  // payload qualified by the valid bits above
  always_ff @(posedge clk) begin
    s1_queue      <= req_queue;
    s2_queue      <= s1_queue;
    s2_grant      <= s1_grant;
    wb_queue_q    <= ram_waddr2;
    wb_data_q     <= ram_wdata2;
    snoop_queue_q <= snoop_waddr;
    snoop_data_q  <= snoop_wdata;
    resp_queue    <= s2_queue;
    resp_grant    <= s2_grant;
  end

  // ------------------------------------------------------------------
  // stage 1 forwarding, decision and writeback
  // ------------------------------------------------------------------

  // own writeback beats an apb write to the same queue just as port 2 wins in the ram
  always_comb begin
    if (wb_valid_q && (wb_queue_q == s1_queue)) begin
      s1_count = wb_data_q;
    end else if (snoop_valid_q && (snoop_queue_q == s1_queue)) begin
      s1_count = snoop_data_q;
    end else begin
      s1_count = ram_rdata;
    end
  end

  // any credit left grants while an empty queue is denied and left untouched
  assign s1_grant = s1_valid && (s1_count != '0);

  assign ram_we2    = s1_grant;
  assign ram_waddr2 = s1_queue;
  assign ram_wdata2 = s1_count - 1'b1;

  // ------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------

  // a writeback is one below the forwarded count without wrapping
  a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    ram_we2 |-> (({1'b0, ram_wdata2} + 1'b1) == {1'b0, s1_count}));

endmodule

/* credit_top.sv */
// credit table top level: apb slave, credit ram and grant pipeline
`timescale 1ns/100ps

module credit_top #(
  parameter int NUM_QUEUES   = 8,
  parameter int CREDIT_WIDTH = 8,
  parameter int INIT_CREDIT  = 4
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  // apb slave
  input  logic                                                psel,
  input  logic                                                penable,
  input  logic                                                pwrite,
  input  credit_pkg::apb_addr_t                               paddr,
  input  credit_pkg::apb_data_t                               pwdata,
  output credit_pkg::apb_data_t                               prdata,
  output logic                                                pready,
  // requests
  input  logic                                                req_valid,
  input  logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] req_queue,
  // responses
  output logic                                                resp_valid,
  output logic [credit_pkg::queue_addr_width(NUM_QUEUES)-1:0] resp_queue,
  output logic                                                resp_grant
);

  import credit_pkg::*;

  localparam int QAW = queue_addr_width(NUM_QUEUES);

  // write port 1, also snooped by the grant unit
  logic                    ram_we;
  logic [QAW-1:0]          ram_waddr;
  logic [CREDIT_WIDTH-1:0] ram_wdata;
  // write port 2
  logic                    ram_we2;
  logic [QAW-1:0]          ram_waddr2;
  logic [CREDIT_WIDTH-1:0] ram_wdata2;
  // read requests from both sides
  logic                    apb_re;
  logic [QAW-1:0]          apb_raddr;
  logic                    grant_re;
  logic [QAW-1:0]          grant_raddr;
  // shared read port
  logic                    ram_re;
  logic [QAW-1:0]          ram_raddr;
  logic [CREDIT_WIDTH-1:0] ram_rdata;

  // ------------------------------------------------------------------
  // read port sharing
  // ------------------------------------------------------------------

  // the apb side only asks when req_valid is low, so grant simply wins
  assign ram_re    = grant_re | apb_re;
  assign ram_raddr = grant_re ? grant_raddr : apb_raddr;

  // ------------------------------------------------------------------
  // blocks
  // ------------------------------------------------------------------

  credit_apb_regs #(
    .NUM_QUEUES   (NUM_QUEUES),
    .CREDIT_WIDTH (CREDIT_WIDTH)
  ) i_apb_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .req_valid (req_valid),
    .ram_we    (ram_we),
    .ram_waddr (ram_waddr),
    .ram_wdata (ram_wdata),
    .ram_re    (apb_re),
    .ram_raddr (apb_raddr),
    .ram_rdata (ram_rdata)
  );

  credit_ram #(
    .NUM_QUEUES   (NUM_QUEUES),
    .CREDIT_WIDTH (CREDIT_WIDTH),
    .INIT_CREDIT  (INIT_CREDIT)
  ) i_ram (
    .clk    (clk),
    .rst_n  (rst_n),
    .we     (ram_we),
    .waddr  (ram_waddr),
    .wdata  (ram_wdata),
    .we2    (ram_we2),
    .waddr2 (ram_waddr2),
    .wdata2 (ram_wdata2),
    .re     (ram_re),
    .raddr  (ram_raddr),
    .rdata  (ram_rdata)
  );

  credit_grant #(
    .NUM_QUEUES   (NUM_QUEUES),
    .CREDIT_WIDTH (CREDIT_WIDTH)
  ) i_grant (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req_queue   (req_queue),
    .ram_re      (grant_re),
    .ram_raddr   (grant_raddr),
    .ram_rdata   (ram_rdata),
    .snoop_we    (ram_we),
    .snoop_waddr (ram_waddr),
    .snoop_wdata (ram_wdata),
    .ram_we2     (ram_we2),
    .ram_waddr2  (ram_waddr2),
    .ram_wdata2  (ram_wdata2),
    .resp_valid  (resp_valid),
    .resp_queue  (resp_queue),
    .resp_grant  (resp_grant)
  );

endmodule

/* tb_credit_top.sv */
// credit table testbench with clock, reset, lfsr stimulus, shadow model, checks and watchdog
`timescale 1ns/100ps

module tb_credit_top;

  import credit_pkg::*;

  localparam int NUM_QUEUES   = 8;
  localparam int CREDIT_WIDTH = 8;
  localparam int INIT_CREDIT  = 4;
  localparam int QAW          = queue_addr_width(NUM_QUEUES);
  localparam int CLK_NS       = 8;
  // rough cycle budget of each test in run order
  localparam int TEST_CYCLES  = 40 + 72 + 40 + 100 + 40 + 25;
  localparam int MARGIN       = 200;

  logic clk, rst_n, psel, penable, pwrite, pready;
  apb_addr_t paddr;
  apb_data_t pwdata, prdata;
  logic req_valid, resp_valid, resp_grant;
  logic [QAW-1:0] req_queue, resp_queue;

  // shadow model and its two-stage response prediction
  logic [CREDIT_WIDTH-1:0] model [NUM_QUEUES];
  logic [CREDIT_WIDTH-1:0] cnt, rd_exp;
  logic pend_valid, dec_valid, dec_grant, exp_valid, exp_grant, rd_pending;
  logic [QAW-1:0] pend_q, dec_q, exp_queue;

  logic [15:0] lfsr = 16'd69;
  string test_name;
  int errors, err_start, tests_run, tests_failed, grants, g0, c, qa, qb;
  time rd_done_time, burst_end;

  credit_top #(
    .NUM_QUEUES   (NUM_QUEUES),
    .CREDIT_WIDTH (CREDIT_WIDTH),
    .INIT_CREDIT  (INIT_CREDIT)
  ) i_dut (
    .clk (clk), .rst_n (rst_n),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .prdata (prdata), .pready (pready),
    .req_valid (req_valid), .req_queue (req_queue),
    .resp_valid (resp_valid), .resp_queue (resp_queue), .resp_grant (resp_grant)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------

  // 16 bit fibonacci lfsr with taps 16 14 13 11 stepped once per bit taken
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // junk in the bits above the queue index, which the slave ignores
  function automatic apb_addr_t queue_addr(input int q);
    return CREDIT_REG_BASE + (apb_addr_t'(rand_bits(12 - QAW - 2)) << (QAW + 2))
           + apb_addr_t'(4 * q);
  endfunction

  function automatic int addr_queue(input apb_addr_t a);
    return int'((a - CREDIT_REG_BASE) >> 2) & ((1 << QAW) - 1);
  endfunction

  task automatic wait_ready();
    @(posedge clk);
    while (!pready) @(posedge clk);
  endtask

  task automatic apb_write(input int q, input int val);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = queue_addr(q);
    pwdata  = apb_data_t'(val);
    @(negedge clk);
    penable = 1'b1;
    wait_ready();
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input int q);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = queue_addr(q);
    @(negedge clk);
    penable = 1'b1;
    wait_ready();
    rd_done_time = $time;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // n requests to one queue with gap idle cycles after each
  task automatic send_reqs(input int q, input int n, input int gap);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      req_valid = 1'b1;
      req_queue = QAW'(q);
      repeat (gap) begin
        @(negedge clk);
        req_valid = 1'b0;
      end
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != err_start) tests_failed++;
    $display("test %s done, %0d errors", test_name, errors - err_start);
  endtask

  // grants seen since g0 against the count written before the requests
  task automatic check_grants(input int expected);
    repeat (4) @(negedge clk);
    assert (grants - g0 == expected) else begin
      $display("Fail %s: grants expected %0d actual %0d", test_name, expected, grants - g0);
      errors++;
    end
  endtask

  // ------------------------------------------------------------------
  // shadow model updated once per rising edge
  // ------------------------------------------------------------------

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_QUEUES; i++) model[i] = CREDIT_WIDTH'(INIT_CREDIT);
      {pend_valid, dec_valid, dec_grant, exp_valid, exp_grant, rd_pending} = '0;
      {pend_q, dec_q, exp_queue, rd_exp} = '0;
      grants = 0;
    end else begin
      if (resp_valid && resp_grant) grants++;
      // a read returns the table as it stood before its issue edge
      if (rd_pending) begin
        rd_pending = 1'b0;
      end else if (psel && penable && !pwrite && !req_valid) begin
        rd_exp     = model[addr_queue(paddr)];
        rd_pending = 1'b1;
      end
      exp_valid = dec_valid;
      exp_grant = dec_grant;
      exp_queue = dec_q;
      // request from the previous edge decides on the table after that edge
      cnt       = model[pend_q];
      dec_valid = pend_valid;
      dec_grant = pend_valid && (cnt != '0);
      dec_q     = pend_q;
      if (psel && penable && pwrite && pready) begin
        model[addr_queue(paddr)] = pwdata[CREDIT_WIDTH-1:0];
      end
      // decrement lands after the apb write so it wins a collision
      if (dec_grant) model[dec_q] = cnt - 1'b1;
      pend_valid = req_valid;
      pend_q     = req_queue;
    end
  end

  // ------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------

  a_resp_check: assert property (@(posedge clk) disable iff (!rst_n)
    (resp_valid == exp_valid) &&
    (!exp_valid || ((resp_queue == exp_queue) && (resp_grant == exp_grant))))
  else begin
    $display("Fail %s: response expected v%0b q%0d g%0b, actual v%0b q%0d g%0b",
             test_name, $sampled(exp_valid), $sampled(exp_queue), $sampled(exp_grant),
             $sampled(resp_valid), $sampled(resp_queue), $sampled(resp_grant));
    errors++;
  end

  a_read_check: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && pready && !pwrite) |-> (rd_pending && (prdata == 32'(rd_exp))))
  else begin
    if (!$sampled(rd_pending)) begin
      $display("APB read in %s completed without a RAM read before it", test_name);
    end else begin
      $display("Fail %s: read expected %0d actual %0d",
               test_name, $sampled(rd_exp), $sampled(prdata));
    end
    errors++;
  end

  // writes complete in their first access cycle
  a_write_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && pwrite) |-> pready)
  else begin
    $display("APB write in %s did not complete in its first access cycle", test_name);
    errors++;
  end

  // ------------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------------

  initial begin
    #((TEST_CYCLES + MARGIN) * CLK_NS);
    $display("watchdog expired in test %s, the run did not finish in time", test_name);
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------

  initial begin
    {psel, penable, pwrite, req_valid} = '0;
    paddr     = '0;
    pwdata    = '0;
    req_queue = '0;
    errors    = 0;
    rst_n     = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    start_test("reset_values");
    for (int q = 0; q < NUM_QUEUES; q++) apb_read(q);
    end_test();

    start_test("write_read");
    for (int q = 0; q < NUM_QUEUES; q++) apb_write(q, rand_bits(CREDIT_WIDTH));
    for (int q = 0; q < NUM_QUEUES; q++) apb_read(q);
    end_test();

    // spaced requests run the count down to zero and then get denied
    start_test("drain_queue");
    qa = rand_bits(QAW);
    c  = 2 + rand_bits(2);
    apb_write(qa, c);
    g0 = grants;
    send_reqs(qa, c + 2, 2);
    check_grants(c);
    apb_read(qa);
    end_test();

    // same count twice with back to back requests and then random gaps
    start_test("forwarding");
    qa = rand_bits(QAW);
    c  = 3 + rand_bits(2);
    apb_write(qa, c);
    g0 = grants;
    send_reqs(qa, c + 3, 0);
    check_grants(c);
    apb_read(qa);
    apb_write(qa, c);
    g0 = grants;
    for (int i = 0; i < c + 3; i++) send_reqs(qa, 1, 1 + rand_bits(2));
    check_grants(c);
    apb_read(qa);
    end_test();

    // writeback and apb write on one edge followed by the snoop path
    start_test("write_collision");
    qa = rand_bits(QAW);
    qb = qa ^ 1;
    apb_write(qa, 5);
    fork
      apb_write(qa, 9);
      send_reqs(qa, 1, 0);
    join
    // the decremented count must have survived the colliding write
    apb_read(qa);
    fork
      apb_write(qb, 7);
      send_reqs(qa, 1, 0);
    join
    fork
      apb_write(qa, 6);
      begin
        @(negedge clk);
        send_reqs(qa, 1, 0);
      end
    join
    repeat (4) @(negedge clk);
    apb_read(qa);
    apb_read(qb);
    end_test();

    start_test("read_during_burst");
    qa = rand_bits(QAW);
    qb = qa ^ 1;
    apb_write(qa, 3);
    apb_write(qb, 11);
    fork
      begin
        send_reqs(qa, 8, 0);
        burst_end = $time;
      end
      apb_read(qb);
    join
    assert (rd_done_time > burst_end) else begin
      $display("APB read in %s completed before the request burst ended", test_name);
      errors++;
    end
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* build.f */
credit_pkg.sv
credit_ram.sv
credit_apb_regs.sv
credit_grant.sv
credit_top.sv
tb_credit_top.sv

/* run.sh */
#!/usr/bin/env bash
# builds the credit table testbench with verilator and runs it
# exits nonzero unless the log holds the pass message

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_credit_top --Mdir "$obj" -o tb_credit_top -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$obj/tb_credit_top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$log"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
